// File: common/mem_pkg.sv
package mem_pkg;

    //////////////////////////////////////////////////
    // address map and geometry
    //////////////////////////////////////////////////

    localparam logic [26:0] VIC_BASE = 27'h1800; // addr[31:5] of vic window
    localparam int VIC_REGS  = 32;
    localparam int VIC_WIDTH = 4;
    localparam int VIC_IDX_W = 5;                  // log2 of VIC_REGS

    localparam int DC_LINES = 16;
    localparam int DC_WORDS = 4;                   // words per line
    localparam int DC_IDX_W = 4;                   // line index bits
    localparam int DC_OFF_W = 2;                   // word offset bits
    localparam int DC_TAG_W = 32 - DC_IDX_W - DC_OFF_W - 2;

    localparam int REFILL_CNT_W = 2;

    //////////////////////////////////////////////////
    // enums
    //////////////////////////////////////////////////

    typedef enum logic [1:0] {
        MA_NONE  = 2'b00,
        MA_LOAD  = 2'b01,
        MA_STORE = 2'b10
    } ma_op_t;

    typedef enum logic [1:0] {
        DC_IDLE   = 2'b00,
        DC_REFILL = 2'b01,
        DC_WRITE  = 2'b10,
        DC_DONE   = 2'b11
    } dc_state_t;

    typedef logic [2:0] wb_ctrl_t; // write-back control, passed through

    //////////////////////////////////////////////////
    // structs
    //////////////////////////////////////////////////

    // execute -> memory access
    typedef struct packed {
        logic        valid;
        ma_op_t      op;
        logic        fwd_sel;  // take store data from write-back
        logic [31:0] addr;     // alu result
        logic [31:0] rs2_val;
        logic [31:0] wb_val;   // forwarded write-back value
        logic [31:0] pc;
        logic [4:0]  rd;
        wb_ctrl_t    wb_ctrl;
    } ma_req_t;

    // MA/WB pipeline register
    typedef struct packed {
        logic        valid;
        logic [31:0] alu_rsl;
        logic [31:0] mem_data;
        logic [31:0] pc;
        logic [4:0]  rd;
        wb_ctrl_t    wb_ctrl;
    } ma_wb_t;

    typedef struct packed {
        logic        valid;
        logic        is_store;
        logic [31:0] addr;
        logic [31:0] wdata;
    } dc_req_t;

    typedef struct packed {
        logic        done;   // one cycle pulse
        logic [31:0] rdata;
    } dc_rsp_t;

    // wishbone classic, master to slave
    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [31:0] adr;
        logic [31:0] dat;
        logic [3:0]  sel;
    } wb_m2s_t;

    typedef struct packed {
        logic        ack;
        logic [31:0] dat;
    } wb_s2m_t;

    typedef logic [VIC_REGS-1:0][VIC_WIDTH-1:0] vic_cfg_t;

endpackage

// File: design/vic_config_regs.sv
`timescale 1ns/1ps

module vic_config_regs (
    input  logic                               Clk,
    input  logic                               rst,
    input  logic [mem_pkg::VIC_IDX_W-1:0]      index,
    input  logic [mem_pkg::VIC_WIDTH-1:0]      wdata,
    input  logic                               we,
    output logic [mem_pkg::VIC_WIDTH-1:0]      rdata,
    output mem_pkg::vic_cfg_t                  cfg
);

    mem_pkg::vic_cfg_t regs; // one nibble per interrupt line

    //////////////////////////////////////////////////
    // write port
    //////////////////////////////////////////////////

    always_ff @(posedge Clk) begin
        if (rst) begin
            regs <= '0;                  // all sources unconfigured
        end else if (we) begin
            regs[index] <= wdata;
        end
    end

    //////////////////////////////////////////////////
    // read ports
    //////////////////////////////////////////////////

    // combinational read for loads in the same cycle
    assign rdata = regs[index];

    // whole table goes out to the interrupt controller
    assign cfg = regs;

endmodule

// File: design/mem_access.sv
`timescale 1ns/1ps

module mem_access (
    input  logic                               Clk,
    input  logic                               rst,
    input  mem_pkg::ma_req_t                   req,
    output logic                               stall,
    output mem_pkg::ma_wb_t                    wb_out,
    output mem_pkg::dc_req_t                   dc_req,
    input  mem_pkg::dc_rsp_t                   dc_rsp,
    output logic [mem_pkg::VIC_IDX_W-1:0]      vic_index,
    output logic [mem_pkg::VIC_WIDTH-1:0]      vic_wdata,
    output logic                               vic_we,
    input  logic [mem_pkg::VIC_WIDTH-1:0]      vic_rdata
);

    logic [31:0] store_data;
    logic        is_load;
    logic        is_store;
    logic        in_vic;   // address falls in vic window
    logic        vic_acc;
    logic        mem_acc;
    logic [31:0] load_data;

    //////////////////////////////////////////////////
    // decode
    //////////////////////////////////////////////////

    assign is_load  = req.valid && (req.op == mem_pkg::MA_LOAD);
    assign is_store = req.valid && (req.op == mem_pkg::MA_STORE);

    // forwarding mux for store data
    assign store_data = req.fwd_sel ? req.wb_val : req.rs2_val;

    assign in_vic  = (req.addr[31:mem_pkg::VIC_IDX_W] == mem_pkg::VIC_BASE);
    assign vic_acc = (is_load || is_store) && in_vic;
    assign mem_acc = (is_load || is_store) && !in_vic;

    // vic register port
    assign vic_index = req.addr[mem_pkg::VIC_IDX_W-1:0];
    assign vic_wdata = store_data[mem_pkg::VIC_WIDTH-1:0]; // low nibble only
    assign vic_we    = vic_acc && is_store;

    // cache request, held until done
    assign dc_req.valid    = mem_acc;
    assign dc_req.is_store = is_store;
    assign dc_req.addr     = req.addr;
    assign dc_req.wdata    = store_data;

    assign stall = dc_req.valid && !dc_rsp.done; // vic never stalls

    // load result
    always_comb begin
        load_data = '0;
        if (is_load && vic_acc) begin
            load_data = {{(32 - mem_pkg::VIC_WIDTH){1'b0}}, vic_rdata}; // zero extend
        end else if (is_load && mem_acc) begin
            load_data = dc_rsp.rdata;
        end
    end

    //////////////////////////////////////////////////
    // MA/WB register
    //////////////////////////////////////////////////

    // bubble into write-back while stalled
    always_ff @(posedge Clk) begin
        if (rst) begin
            wb_out.valid <= 1'b0;
        end else begin
            wb_out.valid <= req.valid && !stall;
        end
    end

    always_ff @(posedge Clk) begin
        if (!stall) begin                      // accepting edge
            wb_out.alu_rsl  <= req.addr;
            wb_out.mem_data <= load_data;
            wb_out.pc       <= req.pc;
            wb_out.rd       <= req.rd;
            wb_out.wb_ctrl  <= req.wb_ctrl;
        end
    end

endmodule

// File: dcache/refill_counter.sv
`timescale 1ns/1ps

module refill_counter (
    input  logic                                  Clk,
    input  logic                                  rst,
    input  logic                                  clr,
    input  logic                                  inc,
    output logic [mem_pkg::REFILL_CNT_W-1:0]      value,
    output logic                                  done
);

    localparam logic [mem_pkg::REFILL_CNT_W-1:0] LAST =
        mem_pkg::REFILL_CNT_W'(mem_pkg::DC_WORDS - 1);

    always_ff @(posedge Clk) begin
        if (rst || clr) begin
            value <= '0;
        end else if (inc) begin
            value <= value + 1'b1;   // wraps after the last word
        end
    end

    // high while the last word of the line is on the bus
    assign done = (value == LAST);

endmodule

// File: dcache/dcache_array.sv
`timescale 1ns/1ps

module dcache_array (
    input  logic                               Clk,
    input  logic                               rst,
    input  logic [31:0]                        addr,
    output logic                               hit,
    output logic [31:0]                        rdata,
    input  logic                               we,
    input  logic                               fill_last,
    input  logic [mem_pkg::DC_OFF_W-1:0]       word,
    input  logic [31:0]                        wdata
);

    localparam int IDX_LSB = mem_pkg::DC_OFF_W + 2;
    localparam int TAG_LSB = IDX_LSB + mem_pkg::DC_IDX_W;

    logic [mem_pkg::DC_TAG_W-1:0] tags [mem_pkg::DC_LINES];
    logic [mem_pkg::DC_LINES-1:0] valid;
    logic [31:0]                  data [mem_pkg::DC_LINES][mem_pkg::DC_WORDS];

    logic [mem_pkg::DC_IDX_W-1:0] idx;
    logic [mem_pkg::DC_TAG_W-1:0] tag;
    logic [mem_pkg::DC_OFF_W-1:0] off;

    //////////////////////////////////////////////////
    // address split
    //////////////////////////////////////////////////

    assign off = addr[IDX_LSB-1:2];       // word in line
    assign idx = addr[TAG_LSB-1:IDX_LSB];
    assign tag = addr[31:TAG_LSB];

    //////////////////////////////////////////////////
    // lookup
    //////////////////////////////////////////////////

    assign hit   = valid[idx] && (tags[idx] == tag);
    assign rdata = data[idx][off];        // valid only with hit

    //////////////////////////////////////////////////
    // storage
    //////////////////////////////////////////////////

    always_ff @(posedge Clk) begin
        if (rst) begin
            valid <= '0;                  // cold cache
        end else if (we && fill_last) begin
            valid[idx] <= 1'b1;           // line complete
        end
    end

    always_ff @(posedge Clk) begin
        if (we) begin
            data[idx][word] <= wdata;     // refill word or store hit
            if (fill_last) begin
                tags[idx] <= tag;
            end
        end
    end

endmodule

// File: dcache/dcache_ctrl.sv
`timescale 1ns/1ps

module dcache_ctrl (
    input  logic                                  Clk,
    input  logic                                  rst,
    input  mem_pkg::dc_req_t                      req,
    output mem_pkg::dc_rsp_t                      rsp,
    output mem_pkg::wb_m2s_t                      wbm,
    input  mem_pkg::wb_s2m_t                      wbs,
    input  logic                                  arr_hit,
    input  logic [31:0]                           arr_rdata,
    output logic                                  arr_we,
    output logic                                  arr_fill_last,
    output logic [mem_pkg::DC_OFF_W-1:0]          arr_word,
    output logic [31:0]                           arr_wdata,
    output logic                                  cnt_clr,
    output logic                                  cnt_inc,
    input  logic [mem_pkg::REFILL_CNT_W-1:0]      cnt_value,
    input  logic                                  cnt_done
);

    mem_pkg::dc_state_t state;
    mem_pkg::dc_state_t state_nxt;
    logic               cyc_q;     // bus cycle in flight
    logic               cyc_nxt;
    logic               is_load;
    logic               ack;       // ack of our own cycle

    assign is_load = req.valid && !req.is_store;
    assign ack     = cyc_q && wbs.ack;

    //////////////////////////////////////////////////
    // state register
    //////////////////////////////////////////////////

    always_ff @(posedge Clk) begin
        if (rst) begin
            state <= mem_pkg::DC_IDLE;
            cyc_q <= 1'b0;
        end else begin
            state <= state_nxt;
            cyc_q <= cyc_nxt;
        end
    end

    //////////////////////////////////////////////////
    // next state and array / counter controls
    //////////////////////////////////////////////////

    always_comb begin
        state_nxt     = state;
        cyc_nxt       = cyc_q;
        rsp.done      = 1'b0;
        rsp.rdata     = '0;
        arr_we        = 1'b0;
        arr_fill_last = 1'b0;
        arr_word      = req.addr[mem_pkg::DC_OFF_W+1:2]; // requested word
        arr_wdata     = req.wdata;
        cnt_clr       = 1'b0;
        cnt_inc       = 1'b0;
        case (state)
            mem_pkg::DC_IDLE: begin
                if (req.valid) begin
                    if (req.is_store) begin
                        state_nxt = mem_pkg::DC_WRITE;   // write-through
                        cyc_nxt   = 1'b1;
                    end else if (arr_hit) begin
                        rsp.done  = 1'b1;                // hit answers at once
                        rsp.rdata = arr_rdata;
                    end else begin
                        state_nxt = mem_pkg::DC_REFILL;
                        cyc_nxt   = 1'b1;
                        cnt_clr   = 1'b1;
                    end
                end
            end
            mem_pkg::DC_WRITE: begin
                if (ack) begin
                    cyc_nxt   = 1'b0;
                    state_nxt = mem_pkg::DC_DONE;
                    arr_we    = arr_hit;                 // no allocate on miss
                end
            end
            mem_pkg::DC_REFILL: begin
                if (ack) begin
                    arr_we        = 1'b1;
                    arr_word      = cnt_value;
                    arr_wdata     = wbs.dat;
                    arr_fill_last = cnt_done;            // tag + valid on last word
                    cnt_inc       = 1'b1;
                    cyc_nxt       = 1'b0;                // one idle cycle between words
                    if (cnt_done) begin
                        state_nxt = mem_pkg::DC_DONE;
                    end
                end else if (!cyc_q) begin
                    cyc_nxt = 1'b1;                      // next word
                end
            end
            mem_pkg::DC_DONE: begin
                rsp.done  = 1'b1;
                rsp.rdata = is_load ? arr_rdata : 32'h0; // line now resident
                state_nxt = mem_pkg::DC_IDLE;
            end
            default: state_nxt = mem_pkg::DC_IDLE;
        endcase
    end

    //////////////////////////////////////////////////
    // wishbone master
    //////////////////////////////////////////////////

    assign wbm.cyc = cyc_q;
    assign wbm.stb = cyc_q;
    assign wbm.we  = (state == mem_pkg::DC_WRITE);
    assign wbm.adr = (state == mem_pkg::DC_REFILL) ?
                     {req.addr[31:mem_pkg::DC_OFF_W+2], cnt_value, 2'b00} : // line base + word
                     req.addr;
    assign wbm.dat = req.wdata;
    assign wbm.sel = '1;                 // word accesses only

endmodule

// File: design/mem_subsystem_top.sv
`timescale 1ns/1ps

module mem_subsystem_top (
    input  logic                Clk,
    input  logic                rst,
    input  mem_pkg::ma_req_t    ma_req,
    output logic                stall,
    output mem_pkg::ma_wb_t     ma_wb,
    output mem_pkg::wb_m2s_t    wbm,
    input  mem_pkg::wb_s2m_t    wbs,
    output mem_pkg::vic_cfg_t   vic_cfg
);

    // stage <-> cache
    mem_pkg::dc_req_t dc_req;
    mem_pkg::dc_rsp_t dc_rsp;

    // stage <-> vic regs
    logic [mem_pkg::VIC_IDX_W-1:0] vic_index;
    logic [mem_pkg::VIC_WIDTH-1:0] vic_wdata;
    logic                          vic_we;
    logic [mem_pkg::VIC_WIDTH-1:0] vic_rdata;

    // cache ctrl <-> array / counter
    logic                             arr_hit;
    logic [31:0]                      arr_rdata;
    logic                             arr_we;
    logic                             arr_fill_last;
    logic [mem_pkg::DC_OFF_W-1:0]     arr_word;
    logic [31:0]                      arr_wdata;
    logic                             cnt_clr;
    logic                             cnt_inc;
    logic [mem_pkg::REFILL_CNT_W-1:0] cnt_value;
    logic                             cnt_done;

    //////////////////////////////////////////////////
    // instances
    //////////////////////////////////////////////////

    mem_access u_mem_access (
        .Clk(Clk), .rst(rst), .req(ma_req), .stall(stall), .wb_out(ma_wb),
        .dc_req(dc_req), .dc_rsp(dc_rsp),
        .vic_index(vic_index), .vic_wdata(vic_wdata), .vic_we(vic_we),
        .vic_rdata(vic_rdata)
    );

    vic_config_regs u_vic_regs (
        .Clk(Clk), .rst(rst), .index(vic_index), .wdata(vic_wdata), .we(vic_we),
        .rdata(vic_rdata), .cfg(vic_cfg)
    );

    dcache_ctrl u_dcache_ctrl (
        .Clk(Clk), .rst(rst), .req(dc_req), .rsp(dc_rsp), .wbm(wbm), .wbs(wbs),
        .arr_hit(arr_hit), .arr_rdata(arr_rdata), .arr_we(arr_we),
        .arr_fill_last(arr_fill_last), .arr_word(arr_word), .arr_wdata(arr_wdata),
        .cnt_clr(cnt_clr), .cnt_inc(cnt_inc), .cnt_value(cnt_value), .cnt_done(cnt_done)
    );

    refill_counter u_refill_cnt (
        .Clk(Clk), .rst(rst), .clr(cnt_clr), .inc(cnt_inc),
        .value(cnt_value), .done(cnt_done)
    );

    // array is looked up with the live request address
    dcache_array u_dcache_array (
        .Clk(Clk), .rst(rst), .addr(dc_req.addr), .hit(arr_hit), .rdata(arr_rdata),
        .we(arr_we), .fill_last(arr_fill_last), .word(arr_word), .wdata(arr_wdata)
    );

endmodule

// File: testbench/mem_tb_tasks.svh
//////////////////////////////////////////////////
// checking helpers
//////////////////////////////////////////////////

task automatic compare_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
        $display("** Error: %s = %h, expected %h at %0t", name, got, exp, $time);
        errors++;
        test_errors++;
    end
endtask

task automatic check_condition(input logic cond, input string what);
    checks++;
    assert (cond) else begin
        $display("Error: %s at %0t", what, $time);
        errors++;
        test_errors++;
    end
endtask

task automatic report_test(input string name);
    tests_run++;
    if (test_errors == 0) begin
        $display("%-26s ok", name);
    end else begin
        $display("%-26s failed, %0d errors", name, test_errors);
    end
    test_errors = 0;
endtask

// random pc, rd and wb control to see them pass through
function automatic mem_pkg::ma_req_t build_request(input mem_pkg::ma_op_t op,
        input logic [31:0] addr, input logic [31:0] rs2, input logic [31:0] wbv,
        input logic fwd);
    mem_pkg::ma_req_t r;
    r.valid   = 1'b1;
    r.op      = op;
    r.fwd_sel = fwd;
    r.addr    = addr;
    r.rs2_val = rs2;
    r.wb_val  = wbv;
    r.pc      = $urandom;
    r.rd      = 5'($urandom);
    r.wb_ctrl = 3'($urandom);
    return r;
endfunction

// called on a falling edge; returns on the falling edge after acceptance
task automatic send_request(input mem_pkg::ma_req_t r, output mem_pkg::ma_wb_t wb,
                            output int stalls);
    stalls = 0;
    bus_log.delete();
    ma_req = r;
    #1;
    while (stall) begin
        @(negedge Clk);
        #1;
        stalls++;
    end
    @(negedge Clk);            // accepting edge has passed
    wb     = ma_wb;
    ma_req = '0;
endtask

task automatic check_wb_fields(input mem_pkg::ma_req_t r, input mem_pkg::ma_wb_t wb,
                               input logic [31:0] exp_data);
    compare_value("ma_wb.valid", wb.valid, r.valid);
    if (r.valid) begin
        compare_value("ma_wb.alu_rsl", wb.alu_rsl, r.addr);
        compare_value("ma_wb.mem_data", wb.mem_data, exp_data);
        compare_value("ma_wb.pc", wb.pc, r.pc);
        compare_value("ma_wb.rd", wb.rd, r.rd);
        compare_value("ma_wb.wb_ctrl", wb.wb_ctrl, r.wb_ctrl);
    end
endtask

task automatic load_and_check(input logic [31:0] addr, input logic [31:0] exp,
                              input int exp_cycles);
    mem_pkg::ma_req_t r;
    mem_pkg::ma_wb_t  wb;
    int               stalls;
    r = build_request(mem_pkg::MA_LOAD, addr, $urandom, $urandom, 1'b0);
    send_request(r, wb, stalls);
    check_wb_fields(r, wb, exp);
    compare_value("bus cycles", bus_log.size(), exp_cycles);
    if (exp_cycles == 0) begin
        compare_value("stall cycles", stalls, 0);
    end else begin
        check_condition(stalls > 0, "load miss went through without a stall");
    end
endtask

// store data is wb_val with fwd set, rs2_val otherwise
task automatic store_and_check(input logic [31:0] addr, input logic [31:0] rs2,
                               input logic [31:0] wbv, input logic fwd, input logic to_bus);
    mem_pkg::ma_req_t r;
    mem_pkg::ma_wb_t  wb;
    int               stalls;
    logic [31:0]      data;
    data = fwd ? wbv : rs2;
    r    = build_request(mem_pkg::MA_STORE, addr, rs2, wbv, fwd);
    send_request(r, wb, stalls);
    check_wb_fields(r, wb, 32'h0);            // stores carry no load data
    if (to_bus) begin
        compare_value("bus cycles", bus_log.size(), 1);
        if (bus_log.size() == 1) begin
            compare_value("wbm.we", bus_log[0].we, 1'b1);
            compare_value("wbm.adr", bus_log[0].adr, addr);
            compare_value("wbm.dat", bus_log[0].dat, data);
            compare_value("wbm.sel", bus_log[0].sel, 4'hf);
        end
        compare_value("memory word", mem[addr[11:2]], data);
    end else begin
        compare_value("bus cycles", bus_log.size(), 0);
        compare_value("stall cycles", stalls, 0);
    end
endtask

//////////////////////////////////////////////////
// directed tests
//////////////////////////////////////////////////

task automatic check_reset_state();
    compare_value("stall", stall, 1'b0);
    compare_value("ma_wb.valid", ma_wb.valid, 1'b0);
    compare_value("wbm.cyc", wbm.cyc, 1'b0);
    compare_value("wbm.stb", wbm.stb, 1'b0);
    check_condition(vic_cfg == '0, "VIC table not cleared by reset");
    report_test("reset state");
endtask

task automatic load_miss_then_hit();
    int k;
    load_and_check(32'h0000_0108, model_word(32'h0000_0108), 4);
    for (k = 0; k < bus_log.size(); k++) begin   // refill walks the line
        compare_value("wbm.adr", bus_log[k].adr, 32'h0000_0100 + 4 * k);
        compare_value("wbm.we", bus_log[k].we, 1'b0);
        compare_value("wbm.sel", bus_log[k].sel, 4'hf);
    end
    load_and_check(32'h0000_010c, model_word(32'h0000_010c), 0);
    load_and_check(32'h0000_0100, model_word(32'h0000_0100), 0);
    report_test("load miss then hit");
endtask

task automatic write_through_store();
    store_and_check(32'h0000_0104, 32'hcafe_0104, 32'h0bad_0104, 1'b0, 1'b1);
    load_and_check(32'h0000_0104, 32'hcafe_0104, 0);     // hit sees new word
    store_and_check(32'h0000_0210, 32'h1234_0210, 32'h0bad_0210, 1'b0, 1'b1);
    load_and_check(32'h0000_0210, 32'h1234_0210, 4);     // no allocate, so a miss
    report_test("write-through store");
endtask

task automatic store_data_forwarding();
    store_and_check(32'h0000_010c, 32'h1111_aaaa, 32'h2222_bbbb, 1'b1, 1'b1);
    load_and_check(32'h0000_010c, 32'h2222_bbbb, 0);
    store_and_check(32'h0000_0108, 32'h3333_cccc, 32'h4444_dddd, 1'b0, 1'b1);
    load_and_check(32'h0000_0108, 32'h3333_cccc, 0);
    report_test("store data forwarding");
endtask

task automatic vic_window_access();
    logic [3:0]  nib [32];       // expected table
    logic [31:0] rs2;
    logic [31:0] wbv;
    int          i;
    for (i = 0; i < 32; i++) begin
        rs2    = $urandom;
        wbv    = $urandom;
        nib[i] = i[0] ? wbv[3:0] : rs2[3:0];
        store_and_check(32'h0003_0000 + i, rs2, wbv, i[0], 1'b0);
        compare_value($sformatf("vic_cfg[%0d]", i), vic_cfg[i], nib[i]);
    end
    for (i = 0; i < 32; i++) begin
        load_and_check(32'h0003_0000 + i, {28'h0, nib[i]}, 0);  // zero extended
        compare_value($sformatf("vic_cfg[%0d]", i), vic_cfg[i], nib[i]);
    end
    report_test("VIC window");
endtask

task automatic passthrough_and_bubbles();
    mem_pkg::ma_req_t r;
    mem_pkg::ma_wb_t  wb;
    int               stalls;
    int               i;
    for (i = 0; i < 4; i++) begin
        r = build_request(mem_pkg::MA_NONE, $urandom, $urandom, $urandom, 1'b0);
        send_request(r, wb, stalls);
        check_wb_fields(r, wb, 32'h0);
        compare_value("stall cycles", stalls, 0);
        compare_value("bus cycles", bus_log.size(), 0);
    end
    // invalid load to a cold line, a bubble
    r       = build_request(mem_pkg::MA_LOAD, 32'h0000_0320, 32'h0, 32'h0, 1'b0);
    r.valid = 1'b0;
    send_request(r, wb, stalls);
    check_wb_fields(r, wb, 32'h0);
    compare_value("stall cycles", stalls, 0);
    compare_value("bus cycles", bus_log.size(), 0);
    load_and_check(32'h0000_0320, model_word(32'h0000_0320), 4);  // bubble left it cold
    report_test("pass-through and bubbles");
endtask

// File: testbench/tb_mem_subsystem.sv
`timescale 1ns/1ps

module tb_mem_subsystem;

    localparam int          MEM_WORDS   = 1024;
    localparam logic [31:0] FILL_KEY    = 32'h5a3c_96e1;  // xor key of the fill pattern
    localparam int          MAX_REQS    = 100;            // about 80 requests in the run
    localparam int          CYC_PER_REQ = 20;             // refill with 3 cycle acks
    localparam int          CYCLE_LIMIT = MAX_REQS * CYC_PER_REQ;

    // one wishbone cycle as seen by the monitor
    typedef struct packed {
        logic        we;
        logic [31:0] adr;
        logic [31:0] dat;
        logic [3:0]  sel;
    } bus_rec_t;

    logic              Clk;
    logic              rst;
    mem_pkg::ma_req_t  ma_req;
    logic              stall;
    mem_pkg::ma_wb_t   ma_wb;
    mem_pkg::wb_m2s_t  wbm;
    mem_pkg::wb_s2m_t  wbs;
    mem_pkg::vic_cfg_t vic_cfg;

    logic [31:0] mem [MEM_WORDS];  // external memory behind the bus
    int          ack_delay;
    logic        busy;             // slave has seen the strobe
    logic        cyc_prev;
    bus_rec_t    seen_rec;
    bus_rec_t    bus_log [$];      // cycles caused by the current request
    int          bus_cycles;
    int          cycle_count;
    int          errors;
    int          checks;
    int          test_errors;
    int          tests_run;

    always #50 Clk = ~Clk;

    mem_subsystem_top DUT (
        .Clk(Clk), .rst(rst), .ma_req(ma_req), .stall(stall), .ma_wb(ma_wb),
        .wbm(wbm), .wbs(wbs), .vic_cfg(vic_cfg)
    );

    // word held at a byte address before any store
    function automatic logic [31:0] model_word(input logic [31:0] addr);
        return {addr[31:2], 2'b00} ^ FILL_KEY;
    endfunction

    //////////////////////////////////////////////////
    // wishbone slave model
    //////////////////////////////////////////////////

    always @(negedge Clk) begin
        if (rst) begin
            wbs       = '0;
            busy      = 1'b0;
            ack_delay = 0;
        end else if (wbs.ack) begin
            wbs.ack = 1'b0;                        // master sampled it, cycle ends
            busy    = 1'b0;
        end else if (wbm.cyc && wbm.stb) begin
            if (!busy) begin
                busy      = 1'b1;
                ack_delay = $urandom % 3;          // ack after 1 to 3 cycles
            end
            if (ack_delay == 0) begin
                if (wbm.we) begin
                    mem[wbm.adr[11:2]] = wbm.dat;
                end
                wbs.dat = mem[wbm.adr[11:2]];
                wbs.ack = 1'b1;
            end else begin
                ack_delay = ack_delay - 1;
            end
        end
    end

    // bus monitor, logs each new cycle
    always @(negedge Clk) begin
        if (wbm.cyc && !cyc_prev) begin
            seen_rec.we  = wbm.we;
            seen_rec.adr = wbm.adr;
            seen_rec.dat = wbm.dat;
            seen_rec.sel = wbm.sel;
            bus_log.push_back(seen_rec);
            bus_cycles++;
        end
        cyc_prev = wbm.cyc;
    end

    // run length guard
    always @(posedge Clk) begin
        cycle_count++;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("timeout: run went past %0d cycles", CYCLE_LIMIT);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    `include "mem_tb_tasks.svh"

    //////////////////////////////////////////////////
    // test sequence
    //////////////////////////////////////////////////

    initial begin
        Clk         = 1'b0;
        rst         = 1'b1;
        ma_req      = '0;
        wbs         = '0;
        cyc_prev    = 1'b0;
        bus_cycles  = 0;
        cycle_count = 0;
        errors      = 0;
        checks      = 0;
        test_errors = 0;
        tests_run   = 0;
        void'($urandom(32'h25cf_0511));   // seeds the whole run
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = model_word(32'(i) << 2);
        end
        repeat (2) @(posedge Clk);
        @(negedge Clk);
        rst = 1'b0;

        check_reset_state();
        load_miss_then_hit();
        write_through_store();
        store_data_forwarding();
        vic_window_access();
        passthrough_and_bubbles();

        $display("%0d tests, %0d checks, %0d errors, %0d bus cycles",
                 tests_run, checks, errors, bus_cycles);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// File: project.f
+incdir+testbench
common/mem_pkg.sv
design/vic_config_regs.sv
design/mem_access.sv
dcache/refill_counter.sv
dcache/dcache_array.sv
dcache/dcache_ctrl.sv
design/mem_subsystem_top.sv
testbench/tb_mem_subsystem.sv
